//--- design/rtg_video_pkg.sv
// Colour channel widths, channel type and OSD colour patterns for the RTG video output stage
package rtg_video_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channel widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int CHANNEL_W  = 8;                     // One colour channel
  localparam int OSD_PAT_W  = 2;                     // OSD bits on top of a channel
  localparam int OSD_KEEP_W = CHANNEL_W - OSD_PAT_W; // Video bits left under the OSD

  typedef logic [CHANNEL_W-1:0] channel_t;
  typedef logic [OSD_PAT_W-1:0] osd_pat_t;

  ////////////////////////////////////////////////////////////////////////////
  // OSD colours
  ////////////////////////////////////////////////////////////////////////////

  // Foreground is plain white
  localparam osd_pat_t OSD_FG_R = 2'b11;
  localparam osd_pat_t OSD_FG_G = 2'b11;
  localparam osd_pat_t OSD_FG_B = 2'b11;

  // Background tints the video toward yellow
  localparam osd_pat_t OSD_BG_R = 2'b11;
  localparam osd_pat_t OSD_BG_G = 2'b11;
  localparam osd_pat_t OSD_BG_B = 2'b10;

endpackage

//--- design/rtg_fetch_pkg.sv
// Pixel word, divider and line-count widths plus state encodings for the RTG fetch path
package rtg_fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int PIXEL_W = 16; // Hi-colour word from the frame store
  localparam int DIV_W   = 4;  // Clocks per fetch, minus one
  localparam int LINE_W  = 7;  // Extra vertical-blank lines

  typedef logic [PIXEL_W-1:0] pixel_word_t;
  typedef logic [DIV_W-1:0]   pixel_div_t;
  typedef logic [LINE_W-1:0]  vb_line_t;

  ////////////////////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////////////////////

  // Four-phase frame-store handshake
  typedef enum logic [1:0] {
    FETCH_IDLE    = 2'd0, // Waiting for a fetch strobe
    FETCH_REQ     = 2'd1, // Request out, waiting for ack
    FETCH_RELEASE = 2'd2  // Request dropped, waiting for ack low
  } fetch_state_t;

  // Vertical blank extension
  typedef enum logic {
    VB_ACTIVE = 1'b0,
    VB_EXTEND = 1'b1
  } vblank_state_t;

endpackage

//--- design/rtg_line_timer.sv
// Extends the chipset vertical blank by a programmed number of lines and forms the RTG blank
`timescale 1ns/1ps

module rtg_line_timer (
  input  logic                   clk_114,
  input  logic                   arst_n,
  input  logic                   hsync,
  input  logic                   hblank,
  input  logic                   vblank,
  input  rtg_fetch_pkg::vb_line_t vb_end,
  output logic                   rtg_blank
);

  rtg_fetch_pkg::vblank_state_t vb_state;
  rtg_fetch_pkg::vb_line_t      line_cnt; // Lines seen since vblank
  logic                         hsync_d;
  logic                         hsync_rise;

  assign hsync_rise = hsync & ~hsync_d;

  ////////////////////////////////////////////////////////////////////////////
  // Line counter
  ////////////////////////////////////////////////////////////////////////////

  // The OS leaves blank where the chipset ends it, so RTG keeps its own count
  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      vb_state <= rtg_fetch_pkg::VB_ACTIVE;
      line_cnt <= '0;
      hsync_d  <= 1'b0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin
        vb_state <= rtg_fetch_pkg::VB_EXTEND; // Restart on every vblank cycle
        line_cnt <= '0;
      end else if (vb_state == rtg_fetch_pkg::VB_EXTEND) begin
        if (line_cnt == vb_end) begin
          vb_state <= rtg_fetch_pkg::VB_ACTIVE;
        end else if (hsync_rise) begin
          line_cnt <= line_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Combined blank
  ////////////////////////////////////////////////////////////////////////////

  // Single "not displaying" flag for the fetch timer and the output stage
  assign rtg_blank = (vb_state == rtg_fetch_pkg::VB_EXTEND) | hblank;

endmodule

//--- design/rtg_pixel_timer.sv
// Divides clk_114 by the programmed pixel width and issues one fetch strobe per RTG pixel
`timescale 1ns/1ps

module rtg_pixel_timer (
  input  logic                     clk_114,
  input  logic                     arst_n,
  input  logic                     rtg_ena,
  input  logic                     rtg_blank,
  input  logic                     fetch_busy,
  input  rtg_fetch_pkg::pixel_div_t pixel_width,
  output logic                     fetch_strobe
);

  rtg_fetch_pkg::pixel_div_t pix_cnt; // Clocks into the current pixel
  logic                      count_en;

  // Freeze while a handshake is outstanding
  assign count_en = rtg_ena & ~rtg_blank & ~fetch_busy;

  // Last clock of the pixel
  assign fetch_strobe = count_en & (pix_cnt == pixel_width);

  ////////////////////////////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt <= '0;
    end else begin
      if (rtg_blank) begin
        pix_cnt <= '0; // Each line starts on a pixel boundary
      end else if (fetch_strobe) begin
        pix_cnt <= '0;
      end else if (count_en) begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

endmodule

//--- design/rtg_fetch_fsm.sv
// Runs the four-phase req/ack handshake with the frame store and holds the fetched pixel word
`timescale 1ns/1ps

module rtg_fetch_fsm (
  input  logic                      clk_114,
  input  logic                      arst_n,
  input  logic                      fetch_strobe,
  input  logic                      pix_ack,
  input  rtg_fetch_pkg::pixel_word_t pix_data,
  output logic                      pix_req,
  output logic                      fetch_busy,
  output rtg_fetch_pkg::pixel_word_t word,
  output logic                      word_valid
);

  rtg_fetch_pkg::fetch_state_t state;
  rtg_fetch_pkg::fetch_state_t state_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      rtg_fetch_pkg::FETCH_IDLE: begin
        if (fetch_strobe) begin
          state_nxt = rtg_fetch_pkg::FETCH_REQ;
        end
      end
      rtg_fetch_pkg::FETCH_REQ: begin
        if (pix_ack) begin
          state_nxt = rtg_fetch_pkg::FETCH_RELEASE; // Word taken this cycle
        end
      end
      rtg_fetch_pkg::FETCH_RELEASE: begin
        if (!pix_ack) begin
          state_nxt = rtg_fetch_pkg::FETCH_IDLE;
        end
      end
      default: state_nxt = rtg_fetch_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      state <= rtg_fetch_pkg::FETCH_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Capture on the first cycle that sees the ack
  always_ff @(posedge clk_114) begin
    if (state == rtg_fetch_pkg::FETCH_REQ && pix_ack) begin
      word <= pix_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign pix_req    = (state == rtg_fetch_pkg::FETCH_REQ); // Straight from the state register
  assign fetch_busy = (state != rtg_fetch_pkg::FETCH_IDLE);

  // Handshake closed, word ready for display
  assign word_valid = (state == rtg_fetch_pkg::FETCH_RELEASE) & ~pix_ack;

endmodule

//--- design/rtg_pixel_out.sv
// Unpacks hi-colour words, selects RTG or native video, overlays the OSD and registers the output
`timescale 1ns/1ps

module rtg_pixel_out (
  input  logic                      clk_114,
  input  logic                      arst_n,
  input  logic                      rtg_ena,
  input  logic                      mode_16bit,
  input  logic                      rtg_blank,
  input  rtg_fetch_pkg::pixel_word_t word,
  input  logic                      word_valid,
  input  rtg_video_pkg::channel_t   native_red,
  input  rtg_video_pkg::channel_t   native_green,
  input  rtg_video_pkg::channel_t   native_blue,
  input  logic                      native_blank,
  input  logic                      osd_window,
  input  logic                      osd_pixel,
  output rtg_video_pkg::channel_t   red,
  output rtg_video_pkg::channel_t   green,
  output rtg_video_pkg::channel_t   blue,
  output logic                      de,
  output logic                      pixel_strobe
);

  rtg_video_pkg::channel_t rtg_red, rtg_green, rtg_blue;
  rtg_video_pkg::channel_t mix_red, mix_green, mix_blue;
  logic                    rtg_sel;

  // OSD pattern on top, video shifted down under it
  function automatic rtg_video_pkg::channel_t osd_mix(input rtg_video_pkg::channel_t c,
                                                      input rtg_video_pkg::osd_pat_t pat);
    osd_mix = {pat, c[rtg_video_pkg::CHANNEL_W-1 -: rtg_video_pkg::OSD_KEEP_W]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Hi-colour unpack
  ////////////////////////////////////////////////////////////////////////////

  // Low bits filled from each field's own MSBs so full scale reaches 8'hff
  assign rtg_red   = mode_16bit ? {word[15:11], word[15:13]} : {word[14:10], word[14:12]};
  assign rtg_green = mode_16bit ? {word[10:5], word[10:9]} : {word[9:5], word[9:7]};
  assign rtg_blue  = {word[4:0], word[4:2]}; // Same in both modes

  // RTG or chipset video
  assign rtg_sel   = rtg_ena & ~rtg_blank;
  assign mix_red   = rtg_sel ? rtg_red : native_red;
  assign mix_green = rtg_sel ? rtg_green : native_green;
  assign mix_blue  = rtg_sel ? rtg_blue : native_blue;

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      red          <= '0;
      green        <= '0;
      blue         <= '0;
      de           <= 1'b0;
      pixel_strobe <= 1'b0;
    end else begin
      if (osd_window) begin
        red   <= osd_mix(mix_red, osd_pixel ? rtg_video_pkg::OSD_FG_R : rtg_video_pkg::OSD_BG_R);
        green <= osd_mix(mix_green, osd_pixel ? rtg_video_pkg::OSD_FG_G : rtg_video_pkg::OSD_BG_G);
        blue  <= osd_mix(mix_blue, osd_pixel ? rtg_video_pkg::OSD_FG_B : rtg_video_pkg::OSD_BG_B);
      end else begin
        red   <= mix_red;
        green <= mix_green;
        blue  <= mix_blue;
      end
      de           <= rtg_ena ? ~rtg_blank : ~native_blank;
      pixel_strobe <= word_valid; // Lines up with the registered colour
    end
  end

endmodule

//--- design/rtg_video_top.sv
// RTG display path top level joining the line timer, pixel timer, fetch FSM and output stage
`timescale 1ns/1ps

module rtg_video_top (
  input  logic                      clk_114,
  input  logic                      arst_n,
  input  logic                      rtg_ena,
  input  logic                      mode_16bit,
  input  rtg_fetch_pkg::pixel_div_t  pixel_width,
  input  rtg_fetch_pkg::vb_line_t    vb_end,
  input  logic                      hsync,       // Chipset timing
  input  logic                      hblank,
  input  logic                      vblank,
  input  rtg_video_pkg::channel_t   native_red,  // Chipset video
  input  rtg_video_pkg::channel_t   native_green,
  input  rtg_video_pkg::channel_t   native_blue,
  input  logic                      native_blank,
  input  logic                      osd_window,
  input  logic                      osd_pixel,
  input  logic                      pix_ack,     // Frame store
  input  rtg_fetch_pkg::pixel_word_t pix_data,
  output logic                      pix_req,
  output rtg_video_pkg::channel_t   red,
  output rtg_video_pkg::channel_t   green,
  output rtg_video_pkg::channel_t   blue,
  output logic                      de,
  output logic                      pixel_strobe
);

  logic                       rtg_blank;
  logic                       fetch_strobe;
  logic                       fetch_busy; // Back-pressure into the divider
  rtg_fetch_pkg::pixel_word_t word;
  logic                       word_valid;

  rtg_line_timer u_line_timer (
    .clk_114 (clk_114), .arst_n (arst_n), .hsync (hsync), .hblank (hblank),
    .vblank (vblank), .vb_end (vb_end), .rtg_blank (rtg_blank)
  );

  rtg_pixel_timer u_pixel_timer (
    .clk_114 (clk_114), .arst_n (arst_n), .rtg_ena (rtg_ena), .rtg_blank (rtg_blank),
    .fetch_busy (fetch_busy), .pixel_width (pixel_width), .fetch_strobe (fetch_strobe)
  );

  rtg_fetch_fsm u_fetch_fsm (
    .clk_114 (clk_114), .arst_n (arst_n), .fetch_strobe (fetch_strobe),
    .pix_ack (pix_ack), .pix_data (pix_data), .pix_req (pix_req),
    .fetch_busy (fetch_busy), .word (word), .word_valid (word_valid)
  );

  rtg_pixel_out u_pixel_out (
    .clk_114 (clk_114), .arst_n (arst_n), .rtg_ena (rtg_ena), .mode_16bit (mode_16bit),
    .rtg_blank (rtg_blank), .word (word), .word_valid (word_valid),
    .native_red (native_red), .native_green (native_green), .native_blue (native_blue),
    .native_blank (native_blank), .osd_window (osd_window), .osd_pixel (osd_pixel),
    .red (red), .green (green), .blue (blue), .de (de), .pixel_strobe (pixel_strobe)
  );

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock of 40 ns period and a power-on reset held low for the first 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_114,
  output logic arst_n
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_114 = 1'b0;
    forever #(HALF_PERIOD) clk_114 = ~clk_114;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_114);
    #5 arst_n = 1'b1; // Mid high phase, clear of both edges
  end

endmodule

//--- verification/rtg_video_tb.sv
// Testbench for the RTG display path; serves pixel words from the stim file and checks the video
`timescale 1ns/1ps

module rtg_video_tb;

  localparam int MAX_ROWS   = 32;
  localparam int WAIT_LIMIT = 200; // Cycles per wait
  localparam int VB_LINES   = 4;

  logic clk_114, arst_n;
  logic rtg_ena, mode_16bit, hsync, hblank, vblank;
  rtg_fetch_pkg::pixel_div_t  pixel_width;
  rtg_fetch_pkg::vb_line_t    vb_end;
  rtg_video_pkg::channel_t    native_red, native_green, native_blue;
  logic native_blank, osd_window, osd_pixel, pix_ack;
  rtg_fetch_pkg::pixel_word_t pix_data;
  logic pix_req, de, pixel_strobe;
  rtg_video_pkg::channel_t    red, green, blue;

  // Rows of the stim file
  int                         row_test [MAX_ROWS];
  logic                       row_m16 [MAX_ROWS];
  logic                       row_osd_win [MAX_ROWS];
  logic                       row_osd_pix [MAX_ROWS];
  rtg_fetch_pkg::pixel_word_t row_word [MAX_ROWS];
  rtg_video_pkg::channel_t    row_red [MAX_ROWS];
  rtg_video_pkg::channel_t    row_green [MAX_ROWS];
  rtg_video_pkg::channel_t    row_blue [MAX_ROWS];
  int                         num_rows;

  int          mismatch_errs, proto_errs, timeout_errs, other_errs;
  int          ack_cnt, strobe_cnt;
  logic        req_prev;
  logic        aborted; // Any timeout stops the rest of the sequence
  logic [31:0] rnd;

  tb_clock_gen u_clock_gen (.clk_114 (clk_114), .arst_n (arst_n));

  rtg_video_top UUT (
    .clk_114 (clk_114), .arst_n (arst_n), .rtg_ena (rtg_ena), .mode_16bit (mode_16bit),
    .pixel_width (pixel_width), .vb_end (vb_end), .hsync (hsync), .hblank (hblank),
    .vblank (vblank), .native_red (native_red), .native_green (native_green),
    .native_blue (native_blue), .native_blank (native_blank), .osd_window (osd_window),
    .osd_pixel (osd_pixel), .pix_ack (pix_ack), .pix_data (pix_data), .pix_req (pix_req),
    .red (red), .green (green), .blue (blue), .de (de), .pixel_strobe (pixel_strobe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (aborted) return;
    assert (got === exp) else begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (aborted) return;
    assert (got === exp) else begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_idle(input string when);
    check_bit({when, " pix_req"}, pix_req, 1'b0);
    check_bit({when, " de"}, de, 1'b0);
    check_bit({when, " pixel_strobe"}, pixel_strobe, 1'b0);
    check_val({when, " red"}, red, 8'h00);
    check_val({when, " green"}, green, 8'h00);
    check_val({when, " blue"}, blue, 8'h00);
  endtask

  task automatic check_strobe_count();
    if (aborted) return;
    assert (strobe_cnt == ack_cnt) else begin
      proto_errs++;
      $display("Handshake error at %0t: %0d pixel strobes for %0d acknowledged words",
               $time, strobe_cnt, ack_cnt);
    end
  endtask

  // One clock; samples on the falling edge, before the caller drives
  task automatic step();
    @(negedge clk_114);
    if (pix_req && !req_prev) begin
      assert (!pix_ack) else begin
        proto_errs++;
        $display("Handshake error at %0t: pix_req rose while pix_ack was high", $time);
      end
    end
    if (!pix_req && req_prev) begin
      assert (pix_ack) else begin
        proto_errs++;
        $display("Handshake error at %0t: pix_req dropped before pix_ack was seen", $time);
      end
    end
    if (pixel_strobe) strobe_cnt++;
    req_prev = pix_req;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    timeout_errs++;
    aborted = 1'b1;
    $display("Timeout at %0t: waited %0d cycles for %s", $time, WAIT_LIMIT, what);
  endtask

  task automatic wait_req(input logic level);
    int n;
    n = 0;
    if (aborted) return;
    while (pix_req !== level && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (pix_req !== level) report_timeout(level ? "pix_req to rise" : "pix_req to drop");
  endtask

  task automatic wait_strobe();
    int n;
    n = 0;
    if (aborted) return;
    while (pixel_strobe !== 1'b1 && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (pixel_strobe !== 1'b1) report_timeout("pixel_strobe");
  endtask

  task automatic wait_de();
    int n;
    n = 0;
    if (aborted) return;
    while (de !== 1'b1 && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (de !== 1'b1) report_timeout("de after the vertical blank");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stim file and frame store
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_stim();
    int          fd;
    int          n;
    int          t, m, w, p;
    logic [15:0] wd;
    logic [7:0]  r, g, b;
    string       line;
    fd = $fopen("verification/rtg_stim.txt", "r");
    if (fd == 0) begin
      other_errs++;
      aborted = 1'b1;
      $display("Could not open verification/rtg_stim.txt");
      return;
    end
    while (num_rows < MAX_ROWS && $fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %d %d %d %h %h %h %h", t, m, w, p, wd, r, g, b);
      if (n == 8) begin
        row_test[num_rows]    = t;
        row_m16[num_rows]     = m[0];
        row_osd_win[num_rows] = w[0];
        row_osd_pix[num_rows] = p[0];
        row_word[num_rows]    = wd;
        row_red[num_rows]     = r;
        row_green[num_rows]   = g;
        row_blue[num_rows]    = b;
        num_rows++;
      end
    end
    $fclose(fd);
    if (num_rows == 0) begin
      other_errs++;
      $display("The stimulus file holds no pixel rows");
    end
  endtask

  // Answers one request with row i, then checks the pixel it produces
  task automatic serve_row(input int i);
    int         delay;
    logic [7:0] exp_r, exp_g, exp_b;
    wait_req(1'b1);
    if (aborted) return;
    delay = $urandom % 6;
    repeat (delay) step();
    mode_16bit = row_m16[i];
    osd_window = row_osd_win[i];
    osd_pixel  = row_osd_pix[i];
    pix_data   = row_word[i];
    pix_ack    = 1'b1;
    ack_cnt++;
    wait_req(1'b0);
    delay = $urandom % 6;
    repeat (delay) step();
    pix_ack = 1'b0;
    wait_strobe();
    if (aborted) return;
    exp_r = row_red[i];
    exp_g = row_green[i];
    exp_b = row_blue[i];
    if (row_osd_win[i]) begin // White foreground, 11/11/10 background
      exp_r = {2'b11, row_red[i][7:2]};
      exp_g = {2'b11, row_green[i][7:2]};
      exp_b = {row_osd_pix[i] ? 2'b11 : 2'b10, row_blue[i][7:2]};
    end
    check_val($sformatf("test %0d red", row_test[i]), red, exp_r);
    check_val($sformatf("test %0d green", row_test[i]), green, exp_g);
    check_val($sformatf("test %0d blue", row_test[i]), blue, exp_b);
    check_bit($sformatf("test %0d de", row_test[i]), de, 1'b1);
    check_strobe_count();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rtg_ena = 1'b0;
    mode_16bit = 1'b0;
    pixel_width = '0;
    vb_end = '0;
    hsync = 1'b0;
    hblank = 1'b0;
    vblank = 1'b0;
    native_red = 8'h5a; // Live native video while reset is held
    native_green = 8'ha5;
    native_blue = 8'h3c;
    native_blank = 1'b0;
    osd_window = 1'b0;
    osd_pixel = 1'b0;
    pix_ack = 1'b0;
    pix_data = '0;
    {mismatch_errs, proto_errs, timeout_errs, other_errs} = '0;
    {ack_cnt, strobe_cnt, num_rows} = '0;
    req_prev = 1'b0;
    aborted = 1'b0;
    rnd = $urandom(32'h96bc);
    load_stim();

    // Reset values, during and just after release before the first clock
    for (int n = 0; n < WAIT_LIMIT && arst_n !== 1'b1; n++) begin
      step();
      if (arst_n === 1'b1) begin
        check_idle("after reset");
      end else begin
        check_idle("in reset");
      end
    end
    if (arst_n !== 1'b1) report_timeout("reset release");

    // Native video with RTG off
    for (int k = 0; k < 6; k++) begin
      rnd = $urandom;
      native_red   = rnd[7:0];
      native_green = rnd[15:8];
      native_blue  = rnd[23:16];
      native_blank = rnd[24];
      step();
      check_val("native red", red, rnd[7:0]);
      check_val("native green", green, rnd[15:8]);
      check_val("native blue", blue, rnd[23:16]);
      check_bit("native de", de, ~rnd[24]);
    end

    // Vertical blank extension, RTG enabled only once blank is up
    vb_end      = rtg_fetch_pkg::vb_line_t'(VB_LINES);
    pixel_width = 4'd2;
    vblank      = 1'b1;
    step();
    rtg_ena = 1'b1;
    step();
    vblank = 1'b0;
    step();
    for (int k = 0; k < VB_LINES; k++) begin
      for (int c = 0; c < 3; c++) begin
        hsync = (c != 0); // One low cycle, then high for two
        step();
        check_bit("de in extended blank", de, 1'b0);
        check_bit("pix_req in extended blank", pix_req, 1'b0);
      end
    end
    hsync = 1'b0;
    wait_de();

    // Unpack and OSD rows in file order
    for (int i = 0; i < num_rows; i++) begin
      serve_row(i);
    end
    repeat (4) step();
    check_strobe_count();

    $display("Errors: %0d mismatch, %0d handshake, %0d timeout, %0d other",
             mismatch_errs, proto_errs, timeout_errs, other_errs);
    if (mismatch_errs + proto_errs + timeout_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/rtg_video_pkg.sv
design/rtg_fetch_pkg.sv
design/rtg_line_timer.sv
design/rtg_pixel_timer.sv
design/rtg_fetch_fsm.sv
design/rtg_pixel_out.sv
design/rtg_video_top.sv
verification/tb_clock_gen.sv
verification/rtg_video_tb.sv

//--- Makefile
# Verilator build and run of the RTG display path testbench

VERILATOR ?= verilator
TOP       ?= rtg_video_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/rtg_stim.txt
# test mode_16bit osd_window osd_pixel word red green blue (word and colours in hex)
# test 1 is 15-bit, test 2 is 16-bit, test 3 is 16-bit under the OSD; colours are unpacked
1 0 0 0 7fff ff ff ff
1 0 0 0 0000 00 00 00
1 0 0 0 7c00 ff 00 00
1 0 0 0 03e0 00 ff 00
1 0 0 0 001f 00 00 ff
1 0 0 0 8000 00 00 00
1 0 0 0 2a55 52 94 ad
2 1 0 0 ffff ff ff ff
2 1 0 0 f800 ff 00 00
2 1 0 0 07e0 00 ff 00
2 1 0 0 0020 00 04 00
2 1 0 0 8410 84 82 84
2 1 0 0 1234 10 45 a5
3 1 1 1 1234 10 45 a5
3 1 1 0 8410 84 82 84
3 1 1 0 ffff ff ff ff
3 1 1 1 0000 00 00 00
